// ==== verilog/cart_load_pkg.sv ====
package cart_load_pkg;

	////////////////////////////////////////
	// load stream widths
	////////////////////////////////////////

	// byte address of the loader
	parameter int ADDR_W_DEF = 25;
	// one loader word
	parameter int DATA_W_DEF = 16;
	// cheat code is {flags, address, compare, replace}, 32 bits each from the top
	parameter int CODE_W = 128;

	////////////////////////////////////////
	// cart header byte addresses
	////////////////////////////////////////

	// region letters
	parameter int unsigned HDR_REGION_ADDR  = 'h1F0;
	parameter int unsigned HDR_REGION_ADDR2 = 'h1F2;
	// first word past the header
	parameter int unsigned HDR_DONE_ADDR    = 'h200;
	// serial number span and the lookup point
	parameter int unsigned CART_ID_FIRST    = 'h182;
	parameter int unsigned CART_ID_LAST     = 'h18A;
	parameter int unsigned CART_ID_CHECK    = 'h18C;

	// light-gun sensor delay
	parameter int GUN_DELAY_W       = 8;
	parameter int GUN_DELAY_DEFAULT = 44;

	// one quirk per cart, a cart matches at most one table entry
	typedef enum logic [3:0] {
		quirk_none, quirk_sram, quirk_eeprom, quirk_noram, quirk_fifo,
		quirk_pier, quirk_svp, quirk_fmbusy, quirk_schan
	} cart_quirk_t;

	// cheat word slot, taken from byte address bits 3..0
	typedef enum logic [3:0] {
		slot_flags_lo = 4'd0, slot_flags_hi = 4'd2, slot_addr_lo = 4'd4, slot_addr_hi = 4'd6,
		slot_cmp_lo = 4'd8, slot_cmp_hi = 4'd10, slot_rep_lo = 4'd12, slot_rep_hi = 4'd14
	} code_slot_t;

endpackage

// ==== verilog/rom_write_bridge.sv ====
`timescale 1ns/1ps

module rom_write_bridge
	import cart_load_pkg::*;
#(
	parameter int ADDR_W = ADDR_W_DEF,
	parameter int DATA_W = DATA_W_DEF
) (
	input  logic              clk_sys,
	input  logic              rst,
	input  logic              load_active,
	input  logic              code_select,
	input  logic              load_wr,
	input  logic [ADDR_W-1:0] load_addr,
	input  logic [DATA_W-1:0] load_data,
	input  logic              mem_ack,
	output logic              load_wait,
	output logic              mem_req,
	output logic [ADDR_W-2:0] mem_addr,
	output logic [DATA_W-1:0] mem_data
);

	typedef enum logic {bridge_idle, bridge_busy} bridge_state_t;

	bridge_state_t state;
	logic          cart_write;

	// cart word, code words go to the cheat loader only
	assign cart_write = load_active & ~code_select & load_wr;

	// wait level follows the word in flight
	assign load_wait = (state == bridge_busy);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state   <= bridge_idle;
			mem_req <= 1'b0;
		end else begin
			case (state)
				bridge_idle: if (cart_write) begin
					// new request is a toggle of mem_req
					mem_req <= ~mem_req;
					state   <= bridge_busy;
				end
				// done once the ack has caught up with the request
				bridge_busy: if (mem_ack == mem_req) state <= bridge_idle;
				default: state <= bridge_idle;
			endcase
		end
	end

	// held from the toggle until completion, memory wants big endian words
	always_ff @(posedge clk_sys) begin
		if (state == bridge_idle && cart_write) begin
			mem_addr <= load_addr[ADDR_W-1:1];
			mem_data <= {<<8{load_data}};
		end
	end

endmodule

// ==== verilog/region_detect.sv ====
`timescale 1ns/1ps

module region_detect
	import cart_load_pkg::*;
#(
	parameter int ADDR_W = ADDR_W_DEF,
	parameter int DATA_W = DATA_W_DEF
) (
	input  logic              clk_sys,
	input  logic              rst,
	input  logic              load_active,
	input  logic              code_select,
	input  logic              load_wr,
	input  logic [ADDR_W-1:0] load_addr,
	input  logic [DATA_W-1:0] load_data,
	output logic              hdr_j,
	output logic              hdr_u,
	output logic              hdr_e,
	output logic              hdr_ready
);

	logic       cart_write;
	logic       active_q;
	// {j, u, e} hits of the current word
	logic [2:0] hit;

	// one region character gives {j, u, e}
	function automatic logic [2:0] region_bits(input logic [7:0] ch);
		if (ch == "J") return 3'b100;
		if (ch == "U") return 3'b010;
		if (ch >= "0" && ch <= "Z") return 3'b001;
		return 3'b000;
	endfunction

	assign cart_write = load_active & ~code_select & load_wr;

	// first region word is checked in both bytes, second in the low byte only
	always_comb begin
		hit = 3'b000;
		if (load_addr == ADDR_W'(HDR_REGION_ADDR))
			hit = region_bits(load_data[7:0]) | region_bits(load_data[DATA_W-1 -: 8]);
		else if (load_addr == ADDR_W'(HDR_REGION_ADDR2))
			hit = region_bits(load_data[7:0]);
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			active_q  <= 1'b0;
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
			hdr_ready <= 1'b0;
		end else begin
			active_q <= load_active;
			// new load starts with no region known
			if (load_active && !active_q) {hdr_j, hdr_u, hdr_e} <= 3'b000;
			if (!load_active && active_q) hdr_ready <= 1'b0;
			if (cart_write) begin
				if (hit[2]) hdr_j <= 1'b1;
				if (hit[1]) hdr_u <= 1'b1;
				if (hit[0]) hdr_e <= 1'b1;
				if (load_addr == ADDR_W'(HDR_DONE_ADDR)) hdr_ready <= 1'b1;
			end
		end
	end

endmodule

// ==== verilog/cart_quirk_table.sv ====
`timescale 1ns/1ps

module cart_quirk_table
	import cart_load_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   load_active,
	input  logic                   code_select,
	input  logic                   load_wr,
	input  logic [ADDR_W_DEF-1:0]  load_addr,
	input  logic [DATA_W_DEF-1:0]  load_data,
	output cart_quirk_t            quirk_kind,
	output logic                   gun_type,
	output logic [GUN_DELAY_W-1:0] gun_delay
);

	logic        cart_write;
	logic        active_q;
	// eight characters, first one in the top byte
	logic [63:0] cart_id;

	assign cart_write = load_active & ~code_select & load_wr;

	////////////////////////////////////////
	// serial collection
	////////////////////////////////////////

	// words come in little endian, characters sit in byte order
	always_ff @(posedge clk_sys) begin
		if (cart_write) begin
			case (load_addr)
				ADDR_W_DEF'(CART_ID_FIRST): cart_id[63:56] <= load_data[15:8];
				ADDR_W_DEF'('h184): cart_id[55:40] <= {load_data[7:0], load_data[15:8]};
				ADDR_W_DEF'('h186): cart_id[39:24] <= {load_data[7:0], load_data[15:8]};
				ADDR_W_DEF'('h188): cart_id[23:8]  <= {load_data[7:0], load_data[15:8]};
				ADDR_W_DEF'(CART_ID_LAST): cart_id[7:0] <= load_data[7:0];
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// table lookup
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			active_q   <= 1'b0;
			quirk_kind <= quirk_none;
			gun_type   <= 1'b0;
			gun_delay  <= GUN_DELAY_W'(GUN_DELAY_DEFAULT);
		end else begin
			active_q <= load_active;
			if (load_active && !active_q) quirk_kind <= quirk_none;
			if (cart_write && load_addr == ADDR_W_DEF'(CART_ID_CHECK)) begin
				// short serials are space padded, unknown ones keep the last quirk
				case (cart_id)
					"T-081276", "T-81406 ": quirk_kind <= quirk_sram;
					"MK-1215 ", "G-4060  ": quirk_kind <= quirk_eeprom;
					"T-113016": quirk_kind <= quirk_noram;
					"T-89016 ": quirk_kind <= quirk_fifo;
					"T-574023": quirk_kind <= quirk_pier;
					"MK-1229 ": quirk_kind <= quirk_svp;
					"T-35036 ": quirk_kind <= quirk_fmbusy;
					"T-68???-": quirk_kind <= quirk_schan;
					default: ;
				endcase
				// gun entry is always rewritten
				case (cart_id)
					"MK-1533 ": {gun_type, gun_delay} <= {1'b0, GUN_DELAY_W'(100)};
					"T-95096-": {gun_type, gun_delay} <= {1'b1, GUN_DELAY_W'(52)};
					"T-95136-": {gun_type, gun_delay} <= {1'b1, GUN_DELAY_W'(30)};
					default:    {gun_type, gun_delay} <= {1'b0, GUN_DELAY_W'(GUN_DELAY_DEFAULT)};
				endcase
			end
		end
	end

endmodule

// ==== verilog/cheat_code_loader.sv ====
`timescale 1ns/1ps

module cheat_code_loader
	import cart_load_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic                  load_active,
	input  logic                  code_select,
	input  logic                  load_wr,
	input  logic [ADDR_W_DEF-1:0] load_addr,
	input  logic [DATA_W_DEF-1:0] load_data,
	output logic [CODE_W-1:0]     code_word,
	output logic                  code_valid,
	output logic                  code_clear
);

	logic       code_write;
	code_slot_t slot;

	// cheat stream is selected by code_select
	assign code_write = load_active & code_select & load_wr;
	assign slot = code_slot_t'(load_addr[3:0]);

	// 16-bit field per slot, odd addresses fall to default
	always_ff @(posedge clk_sys) begin
		if (code_write) begin
			case (slot)
				slot_flags_lo: code_word[111:96]  <= load_data;
				slot_flags_hi: code_word[127:112] <= load_data;
				slot_addr_lo:  code_word[79:64]   <= load_data;
				slot_addr_hi:  code_word[95:80]   <= load_data;
				slot_cmp_lo:   code_word[47:32]   <= load_data;
				slot_cmp_hi:   code_word[63:48]   <= load_data;
				slot_rep_lo:   code_word[15:0]    <= load_data;
				slot_rep_hi:   code_word[31:16]   <= load_data;
				default: ;
			endcase
		end
	end

	// strobes last one cycle
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			code_valid <= 1'b0;
			code_clear <= 1'b0;
		end else begin
			// top replace word closes the code
			code_valid <= code_write && slot == slot_rep_hi;
			code_clear <= code_write && load_addr == '0;
		end
	end

endmodule

// ==== verilog/cart_load_top.sv ====
`timescale 1ns/1ps

module cart_load_top
	import cart_load_pkg::*;
#(
	parameter int ADDR_W = ADDR_W_DEF,
	parameter int DATA_W = DATA_W_DEF
) (
	input  logic                   clk_sys,
	input  logic                   rst,
	// loader side
	input  logic                   load_active,
	input  logic                   code_select,
	input  logic                   load_wr,
	input  logic [ADDR_W-1:0]      load_addr,
	input  logic [DATA_W-1:0]      load_data,
	output logic                   load_wait,
	// rom memory write port, toggle handshake
	output logic                   mem_req,
	input  logic                   mem_ack,
	output logic [ADDR_W-2:0]      mem_addr,
	output logic [DATA_W-1:0]      mem_data,
	// header inspection
	output logic                   hdr_j,
	output logic                   hdr_u,
	output logic                   hdr_e,
	output logic                   hdr_ready,
	output cart_quirk_t            quirk_kind,
	output logic                   gun_type,
	output logic [GUN_DELAY_W-1:0] gun_delay,
	// cheat codes
	output logic [CODE_W-1:0]      code_word,
	output logic                   code_valid,
	output logic                   code_clear
);

	////////////////////////////////////////
	// cart words to memory
	////////////////////////////////////////

	rom_write_bridge #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_bridge (
		.clk_sys(clk_sys), .rst(rst),
		.load_active(load_active), .code_select(code_select), .load_wr(load_wr),
		.load_addr(load_addr), .load_data(load_data), .mem_ack(mem_ack),
		.load_wait(load_wait), .mem_req(mem_req), .mem_addr(mem_addr), .mem_data(mem_data)
	);

	////////////////////////////////////////
	// inspectors watching the same stream
	////////////////////////////////////////

	region_detect #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_region (
		.clk_sys(clk_sys), .rst(rst),
		.load_active(load_active), .code_select(code_select), .load_wr(load_wr),
		.load_addr(load_addr), .load_data(load_data),
		.hdr_j(hdr_j), .hdr_u(hdr_u), .hdr_e(hdr_e), .hdr_ready(hdr_ready)
	);

	// serial lookup and cheat assembly run on 16-bit words
	cart_quirk_table u_quirk (
		.clk_sys(clk_sys), .rst(rst),
		.load_active(load_active), .code_select(code_select), .load_wr(load_wr),
		.load_addr(load_addr), .load_data(load_data),
		.quirk_kind(quirk_kind), .gun_type(gun_type), .gun_delay(gun_delay)
	);

	cheat_code_loader u_cheat (
		.clk_sys(clk_sys), .rst(rst),
		.load_active(load_active), .code_select(code_select), .load_wr(load_wr),
		.load_addr(load_addr), .load_data(load_data),
		.code_word(code_word), .code_valid(code_valid), .code_clear(code_clear)
	);

endmodule

// ==== test/cart_load_assert.sv ====
`timescale 1ns/1ps

module cart_load_checks
	import cart_load_pkg::*;
#(
	parameter int ADDR_W = ADDR_W_DEF,
	parameter int DATA_W = DATA_W_DEF
) (
	input logic              clk_sys,
	input logic              rst,
	input logic              load_active,
	input logic              code_select,
	input logic              load_wr,
	input logic              load_wait,
	input logic              mem_req,
	input logic              mem_ack,
	input logic [ADDR_W-2:0] mem_addr,
	input logic [DATA_W-1:0] mem_data,
	input logic              code_valid
);

	// loader holds cart words while a word is in flight
	no_cart_word_while_wait: assert property (@(posedge clk_sys) disable iff (rst)
		(load_active && !code_select && load_wr) |-> !load_wait)
		else $error("cart word strobed while load_wait is high");

	// memory port held from the toggle until mem_ack catches up
	mem_port_stable: assert property (@(posedge clk_sys) disable iff (rst)
		(mem_req != mem_ack) && $past(mem_req != mem_ack) |-> $stable(mem_addr) && $stable(mem_data))
		else $error("mem_addr or mem_data moved during a pending request");

	// one pulse per completed code
	code_valid_single: assert property (@(posedge clk_sys) disable iff (rst)
		$rose(code_valid) |=> !code_valid)
		else $error("code_valid held longer than one cycle");

endmodule

bind cart_load_top cart_load_checks #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_checks (
	.clk_sys(clk_sys), .rst(rst),
	.load_active(load_active), .code_select(code_select), .load_wr(load_wr),
	.load_wait(load_wait), .mem_req(mem_req), .mem_ack(mem_ack),
	.mem_addr(mem_addr), .mem_data(mem_data), .code_valid(code_valid)
);

// ==== test/tb_cart_load.sv ====
`timescale 1ns/1ps

module tb_cart_load
	import cart_load_pkg::*;
;

	localparam int N_FWD = 200;
	localparam int N_WAIT = 20;
	localparam int N_REGION = 8;
	localparam int N_SERIAL = 16;
	localparam int N_CODES = 4;
	// cart and code strobes of all tests and the three words of the second reset
	localparam int STROBES = N_FWD + N_FWD / 10 + N_WAIT + N_REGION * 3 + N_SERIAL * 6
		+ N_CODES * 8 + 3;
	localparam int CYCLE_LIMIT = STROBES * 12 + 1000;

	////////////////////////////////////////
	// serial table of the cart lookup
	////////////////////////////////////////

	localparam logic [63:0] SERIALS [13] = '{
		"T-081276", "T-81406 ", "MK-1215 ", "G-4060  ", "T-113016", "T-89016 ", "T-574023",
		"MK-1229 ", "T-35036 ", "T-68???-", "MK-1533 ", "T-95096-", "T-95136-"
	};
	localparam cart_quirk_t SERIAL_QUIRK [13] = '{
		quirk_sram, quirk_sram, quirk_eeprom, quirk_eeprom, quirk_noram, quirk_fifo,
		quirk_pier, quirk_svp, quirk_fmbusy, quirk_schan, quirk_none, quirk_none, quirk_none
	};
	// {gun_type, gun_delay}
	localparam logic [8:0] SERIAL_GUN [13] = '{
		9'd44, 9'd44, 9'd44, 9'd44, 9'd44, 9'd44, 9'd44, 9'd44, 9'd44, 9'd44,
		9'd100, {1'b1, 8'd52}, {1'b1, 8'd30}
	};

	logic                   clk_sys;
	logic                   rst;
	logic                   load_active;
	logic                   code_select;
	logic                   load_wr;
	logic [ADDR_W_DEF-1:0]  load_addr;
	logic [DATA_W_DEF-1:0]  load_data;
	logic                   load_wait;
	logic                   mem_req;
	logic                   mem_ack;
	logic [ADDR_W_DEF-2:0]  mem_addr;
	logic [DATA_W_DEF-1:0]  mem_data;
	logic                   hdr_j;
	logic                   hdr_u;
	logic                   hdr_e;
	logic                   hdr_ready;
	cart_quirk_t            quirk_kind;
	logic                   gun_type;
	logic [GUN_DELAY_W-1:0] gun_delay;
	logic [CODE_W-1:0]      code_word;
	logic                   code_valid;
	logic                   code_clear;

	int          cycles = 0;
	int          ack_cycle = 0;
	int          ack_delay = 0;
	int          checks = 0;
	int          errors = 0;
	int          errors_before = 0;
	// quirk kept by the model across lookups of one load
	cart_quirk_t model_quirk;

	cart_load_top #(.ADDR_W(ADDR_W_DEF), .DATA_W(DATA_W_DEF)) dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// run limit
	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, run did not finish", cycles);
			$display("Errors found");
			$finish;
		end
	end

	// memory side acks each request after 1 to 5 cycles
	always @(negedge clk_sys) begin
		if (rst) begin
			mem_ack = 1'b0;
			ack_delay = 0;
		end else if (mem_req != mem_ack) begin
			if (ack_delay == 0) begin
				ack_delay = int'($urandom_range(5, 1));
			end else if (ack_delay == 1) begin
				mem_ack = mem_req;
				ack_delay = 0;
				ack_cycle = cycles;
			end else begin
				ack_delay--;
			end
		end
	end

	////////////////////////////////////////
	// checks and reporting
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond === 1'b1) else begin
			errors++;
			$display("error at %0t: %s", $time, what);
		end
	endtask

	task automatic report_test(input string name);
		$display("test %s finished with %0d errors", name, errors - errors_before);
		errors_before = errors;
	endtask

	task automatic check_reset_values();
		check_value("mem_req", 128'(mem_req), 128'(1'b0));
		check_value("load_wait", 128'(load_wait), 128'(1'b0));
		check_value("code_valid", 128'(code_valid), 128'(1'b0));
		check_value("code_clear", 128'(code_clear), 128'(1'b0));
		check_value("hdr_j/u/e", 128'({hdr_j, hdr_u, hdr_e}), 128'(3'b000));
		check_value("hdr_ready", 128'(hdr_ready), 128'(1'b0));
		check_value("quirk_kind", 128'(quirk_kind), 128'(quirk_none));
		check_value("gun_type", 128'(gun_type), 128'(1'b0));
		check_value("gun_delay", 128'(gun_delay), 128'(GUN_DELAY_W'(GUN_DELAY_DEFAULT)));
	endtask

	////////////////////////////////////////
	// loader side drivers
	////////////////////////////////////////

	// cart word followed by its forwarding and wait checks
	task automatic send_cart_word(input logic [ADDR_W_DEF-1:0] addr, input logic [15:0] data);
		logic exp_req;
		int   n;
		exp_req = ~mem_req;
		code_select = 1'b0;
		load_addr = addr;
		load_data = data;
		load_wr = 1'b1;
		@(negedge clk_sys);
		load_wr = 1'b0;
		check_true(load_wait, "load_wait not high the cycle after a cart word");
		check_value("mem_req", 128'(mem_req), 128'(exp_req));
		n = 0;
		while (load_wait === 1'b1 && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		check_true(load_wait === 1'b0, "load_wait stuck high, request never completed");
		check_value("mem_ack", 128'(mem_ack), 128'(mem_req));
		check_true(cycles - ack_cycle <= 8, "load_wait fell too long after mem_ack");
		check_value("mem_addr", 128'(mem_addr), 128'(addr[ADDR_W_DEF-1:1]));
		check_value("mem_data", 128'(mem_data), 128'({data[7:0], data[15:8]}));
	endtask

	task automatic send_code_word(input logic [ADDR_W_DEF-1:0] addr, input logic [15:0] data);
		code_select = 1'b1;
		load_addr = addr;
		load_data = data;
		load_wr = 1'b1;
		@(negedge clk_sys);
		load_wr = 1'b0;
		code_select = 1'b0;
	endtask

	// rising load_active starts a fresh load
	task automatic start_load();
		load_active = 1'b0;
		@(negedge clk_sys);
		load_active = 1'b1;
		@(negedge clk_sys);
		model_quirk = quirk_none;
	endtask

	// {j, u, e} of one header character
	function automatic logic [2:0] letter_flags(input logic [7:0] c);
		logic [2:0] f;
		f = 3'b000;
		case (c)
			8'h4A: f[2] = 1'b1;
			8'h55: f[1] = 1'b1;
			default: f[0] = (c >= 8'h30 && c <= 8'h5A);
		endcase
		return f;
	endfunction

	// J and U often and any printable character otherwise
	function automatic logic [7:0] pick_letter();
		int r;
		r = int'($urandom_range(3, 0));
		if (r == 0) return 8'h4A;
		if (r == 1) return 8'h55;
		return 8'($urandom_range(126, 32));
	endfunction

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	task automatic forward_words();
		logic req_before;
		for (int i = 0; i < N_FWD; i++) begin
			send_cart_word(ADDR_W_DEF'($urandom), 16'($urandom));
			// code words go past the bridge
			if (i % 10 == 9) begin
				req_before = mem_req;
				send_code_word(ADDR_W_DEF'($urandom), 16'($urandom));
				check_value("mem_req", 128'(mem_req), 128'(req_before));
				check_true(load_wait === 1'b0, "load_wait raised by a code word");
			end
		end
	endtask

	task automatic wait_rule_burst();
		logic [ADDR_W_DEF-1:0] base;
		base = (ADDR_W_DEF'($urandom) >> 1) << 1;
		for (int i = 0; i < N_WAIT; i++)
			send_cart_word(base + ADDR_W_DEF'(2 * i), 16'($urandom));
	endtask

	task automatic region_scan();
		logic [7:0] lo;
		logic [7:0] hi;
		logic [7:0] lo2;
		logic [2:0] exp_flags;
		for (int i = 0; i < N_REGION; i++) begin
			start_load();
			check_value("hdr_j/u/e", 128'({hdr_j, hdr_u, hdr_e}), 128'(3'b000));
			check_value("hdr_ready", 128'(hdr_ready), 128'(1'b0));
			lo = pick_letter();
			hi = pick_letter();
			lo2 = pick_letter();
			send_cart_word(ADDR_W_DEF'(HDR_REGION_ADDR), {hi, lo});
			// high byte of the second word is not examined
			send_cart_word(ADDR_W_DEF'(HDR_REGION_ADDR2), {pick_letter(), lo2});
			exp_flags = letter_flags(lo) | letter_flags(hi) | letter_flags(lo2);
			check_value("hdr_j/u/e", 128'({hdr_j, hdr_u, hdr_e}), 128'(exp_flags));
			check_value("hdr_ready", 128'(hdr_ready), 128'(1'b0));
			send_cart_word(ADDR_W_DEF'(HDR_DONE_ADDR), 16'($urandom));
			check_value("hdr_ready", 128'(hdr_ready), 128'(1'b1));
			load_active = 1'b0;
			@(negedge clk_sys);
			check_value("hdr_ready", 128'(hdr_ready), 128'(1'b0));
		end
	endtask

	task automatic quirk_lookup();
		logic [63:0] serial;
		logic [8:0]  exp_gun;
		int          found;
		start_load();
		for (int i = 0; i < N_SERIAL; i++) begin
			// a new load halfway drops the quirk found so far
			if (i == N_SERIAL / 2) begin
				start_load();
				check_value("quirk_kind", 128'(quirk_kind), 128'(quirk_none));
			end
			if ($urandom_range(3, 0) != 0) begin
				serial = SERIALS[$urandom_range(12, 0)];
			end else begin
				// lower case never matches an entry
				for (int c = 0; c < 8; c++)
					serial = {serial[55:0], 8'($urandom_range(122, 97))};
			end
			send_cart_word(ADDR_W_DEF'(CART_ID_FIRST), {serial[63:56], 8'($urandom)});
			send_cart_word(ADDR_W_DEF'('h184), {serial[47:40], serial[55:48]});
			send_cart_word(ADDR_W_DEF'('h186), {serial[31:24], serial[39:32]});
			send_cart_word(ADDR_W_DEF'('h188), {serial[15:8], serial[23:16]});
			send_cart_word(ADDR_W_DEF'(CART_ID_LAST), {8'($urandom), serial[7:0]});
			send_cart_word(ADDR_W_DEF'(CART_ID_CHECK), 16'($urandom));
			found = -1;
			for (int k = 0; k < 13; k++)
				if (SERIALS[k] == serial) found = k;
			exp_gun = {1'b0, 8'(GUN_DELAY_DEFAULT)};
			if (found >= 0) begin
				exp_gun = SERIAL_GUN[found];
				if (SERIAL_QUIRK[found] != quirk_none) model_quirk = SERIAL_QUIRK[found];
			end
			check_value("quirk_kind", 128'(quirk_kind), 128'(model_quirk));
			check_value("gun_type", 128'(gun_type), 128'(exp_gun[8]));
			check_value("gun_delay", 128'(gun_delay), 128'(exp_gun[7:0]));
		end
	endtask

	task automatic cheat_codes();
		logic [ADDR_W_DEF-1:0] base;
		logic [ADDR_W_DEF-1:0] addr;
		logic [15:0]           w [8];
		for (int c = 0; c < N_CODES; c++) begin
			// first code sits at address 0 to see code_clear
			base = (c == 0) ? '0 : (ADDR_W_DEF'($urandom) >> 4) << 4;
			for (int s = 0; s < 8; s++) begin
				addr = base | ADDR_W_DEF'(2 * s);
				w[s] = 16'($urandom);
				send_code_word(addr, w[s]);
				check_value("code_clear", 128'(code_clear), 128'(addr == '0));
				check_value("code_valid", 128'(code_valid), 128'(s == 7));
			end
			check_value("code_word", 128'(code_word),
				{w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]});
			@(negedge clk_sys);
			check_value("code_valid", 128'(code_valid), 128'(1'b0));
		end
	endtask

	// header flags set and a word still in flight when the reset lands
	task automatic reset_midrun();
		send_cart_word(ADDR_W_DEF'(HDR_REGION_ADDR), {8'h55, 8'h4A});
		send_cart_word(ADDR_W_DEF'(HDR_REGION_ADDR2), {8'h00, 8'h45});
		code_select = 1'b0;
		load_addr = ADDR_W_DEF'(HDR_DONE_ADDR);
		load_data = 16'($urandom);
		load_wr = 1'b1;
		@(negedge clk_sys);
		load_wr = 1'b0;
		check_true(load_wait, "no word in flight before the second reset");
		check_value("hdr_j/u/e", 128'({hdr_j, hdr_u, hdr_e}), 128'(3'b111));
		check_value("hdr_ready", 128'(hdr_ready), 128'(1'b1));
		rst = 1'b1;
		repeat (8) @(negedge clk_sys);
		rst = 1'b0;
		model_quirk = quirk_none;
		@(negedge clk_sys);
		check_reset_values();
	endtask

	initial begin
		void'($urandom(32'h83e4f29d));
		rst = 1'b1;
		load_active = 1'b0;
		code_select = 1'b0;
		load_wr = 1'b0;
		load_addr = '0;
		load_data = '0;
		mem_ack = 1'b0;
		model_quirk = quirk_none;
		repeat (8) @(negedge clk_sys);
		rst = 1'b0;
		@(negedge clk_sys);
		check_reset_values();
		report_test("reset values");

		start_load();
		forward_words();
		report_test("forwarding");
		wait_rule_burst();
		report_test("wait rule");
		region_scan();
		report_test("region");
		quirk_lookup();
		report_test("quirk lookup");
		cheat_codes();
		report_test("cheat codes");
		reset_midrun();
		report_test("second reset");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== files.f ====
verilog/cart_load_pkg.sv
verilog/rom_write_bridge.sv
verilog/region_detect.sv
verilog/cart_quirk_table.sv
verilog/cheat_code_loader.sv
verilog/cart_load_top.sv
test/cart_load_assert.sv
test/tb_cart_load.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cart load testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cart_load -f files.f -o sim_cart_load

# a simulator abort still shows the log before failing
./obj_dir/sim_cart_load > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Errors found" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"
